//--- project.f
+incdir+tb
src/cube_pkg.sv
src/move_permute.sv
src/move_program.sv
src/move_sequencer.sv
src/cube_engine.sv
tb/cube_engine_tb.sv

//--- tb/cube_tb_util.svh
`ifndef CUBE_TB_UTIL_SVH
`define CUBE_TB_UTIL_SVH

// linear congruential generator that hands out its upper bits
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
endfunction

function automatic move_e random_nop();
    logic [31:0] r;
    r = next_rand();
    case (r[1:0])
        2'd0: return move_nop0;
        2'd1: return move_nop1;
        2'd2: return move_nop2;
        default: return move_nop3;
    endcase
endfunction

// one of the twelve quarter turns with codes 2 to 13
function automatic move_e random_turn();
    int sel;
    sel = int'(next_rand() % 12);
    return move_e'(4'(sel + 2));
endfunction

// odd codes undo the even code just below them
function automatic move_e inverse_of(move_e m);
    logic [3:0] code;
    code = m;
    if (code[0]) begin
        return move_e'(code - 4'd1);
    end
    return move_e'(code + 4'd1);
endfunction

function automatic cube_t random_cube();
    cube_t c;
    for (int i = 0; i < num_stickers; i++) begin
        c[i] = sticker_t'(next_rand() % 6);
    end
    return c;
endfunction

function automatic cube_t solved_cube();
    cube_t c;
    for (int i = 0; i < num_stickers; i++) begin
        c[i] = sticker_face[i];
    end
    return c;
endfunction

// first move goes to the top slot and unused slots get random no-ops
function automatic program_t pack_program(input move_e seq[$]);
    program_t p;
    for (int i = 0; i < max_moves; i++) begin
        if (i < seq.size()) begin
            p[max_moves-1-i] = seq[i];
        end else begin
            p[max_moves-1-i] = random_nop();
        end
    end
    return p;
endfunction

function automatic program_t build_program(case_row_t row);
    move_e seq[$];
    case (row.kind)
        prog_turn_inverse: begin
            seq.push_back(row.turn);
            seq.push_back(inverse_of(row.turn));
        end
        prog_turn_four: begin
            repeat (4) seq.push_back(row.turn);
        end
        prog_opposite: begin
            seq.push_back(move_r);
            seq.push_back(move_l);
            seq.push_back(move_ri);
            seq.push_back(move_li);
        end
        prog_ru_six: begin
            repeat (6) begin
                seq.push_back(move_r);
                seq.push_back(move_u);
                seq.push_back(move_ri);
                seq.push_back(move_ui);
            end
        end
        prog_random_undo: begin
            for (int i = 0; i < 25; i++) begin
                seq.push_back(random_turn());
            end
            for (int i = 24; i >= 0; i--) begin
                seq.push_back(inverse_of(seq[i]));
            end
        end
        prog_single: seq.push_back(row.turn);
        default: begin
            // all no-ops
        end
    endcase
    return pack_program(seq);
endfunction

function automatic int count_color(cube_t c, sticker_t color);
    int n;
    n = 0;
    for (int i = 0; i < num_stickers; i++) begin
        if (c[i] == color) n++;
    end
    return n;
endfunction

function automatic int count_diffs(cube_t a, cube_t b);
    int n;
    n = 0;
    for (int i = 0; i < num_stickers; i++) begin
        if (a[i] != b[i]) n++;
    end
    return n;
endfunction

task automatic check_cube(cube_t actual, cube_t expected, string what);
    if (actual !== expected) begin
        errors++;
        $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic check_count(int actual, int expected, string what);
    if (actual != expected) begin
        errors++;
        $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
    end
endtask

task automatic check_done(logic actual, logic expected, string what);
    if (actual !== expected) begin
        errors++;
        $display("[ERROR] %0t: %s: got %b, expected %b", $time, what, actual, expected);
    end
endtask

`endif

//--- tb/cube_engine_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cube_engine_tb
    import cube_pkg::*;
();

    localparam int max_moves = 50;
    localparam int clock_period = 100;
    localparam int done_timeout = 200;
    localparam int expected_latency = max_moves + 1;

    typedef move_e [max_moves-1:0] program_t;

    typedef enum {
        prog_nops,
        prog_turn_inverse,
        prog_turn_four,
        prog_opposite,
        prog_ru_six,
        prog_random_undo,
        prog_single
    } prog_kind_e;

    typedef enum {
        expect_same,
        expect_one_turn
    } expect_e;

    typedef struct {
        prog_kind_e kind;
        move_e      turn;
        logic       from_solved;
        expect_e    rule;
        logic       poke_start;
    } case_row_t;

    logic     clock;
    logic     rst;
    logic     start;
    cube_t    cube_in;
    program_t moves_in;
    cube_t    cube_out;
    logic     done;

    int          errors;
    int          timeouts;
    logic [31:0] lcg_state;
    case_row_t   stim_table[$];

    `include "cube_tb_util.svh"

    cube_engine #(
        .max_moves(max_moves)
    ) cube_engine_i (
        .clock(clock),
        .rst(rst),
        .start(start),
        .cube_in(cube_in),
        .moves_in(moves_in),
        .cube_out(cube_out),
        .done(done)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    task automatic add_row(prog_kind_e kind, move_e turn, logic from_solved,
                           expect_e rule, logic poke_start);
        case_row_t row;
        row.kind = kind;
        row.turn = turn;
        row.from_solved = from_solved;
        row.rule = rule;
        row.poke_start = poke_start;
        stim_table.push_back(row);
    endtask

    task automatic build_table();
        // the first row also pulses start in the middle of the run
        add_row(prog_nops, move_nop0, 1'b0, expect_same, 1'b1);
        add_row(prog_nops, move_nop0, 1'b0, expect_same, 1'b0);
        for (int t = 2; t < 14; t++) begin
            add_row(prog_turn_inverse, move_e'(4'(t)), 1'b0, expect_same, 1'b0);
            add_row(prog_turn_four, move_e'(4'(t)), 1'b0, expect_same, 1'b0);
        end
        add_row(prog_opposite, move_nop0, 1'b0, expect_same, 1'b0);
        add_row(prog_ru_six, move_nop0, 1'b0, expect_same, 1'b0);
        add_row(prog_random_undo, move_nop0, 1'b0, expect_same, 1'b0);
        for (int t = 2; t < 14; t++) begin
            add_row(prog_single, move_e'(4'(t)), 1'b1, expect_one_turn, 1'b0);
        end
    endtask

    // one quarter turn of a solved cube only moves the 12 side stickers
    task automatic check_turn_result(cube_t result, string tag);
        cube_t solved;
        solved = solved_cube();
        for (int i = 48; i < num_stickers; i++) begin
            check_count(int'(result[i]), int'(sticker_face[i]), {tag, " center"});
        end
        for (int c = 0; c < 6; c++) begin
            check_count(count_color(result, sticker_t'(c)), 9, {tag, " color tally"});
        end
        check_count(count_diffs(result, solved), 12, {tag, " changed stickers"});
    endtask

    task automatic run_case(int idx, case_row_t row);
        cube_t    start_cube;
        program_t prog;
        cube_t    result;
        int       cycles;
        string    tag;
        tag = $sformatf("case %0d %s %s", idx, row.kind.name(), row.turn.name());
        start_cube = row.from_solved ? solved_cube() : random_cube();
        prog = build_program(row);
        @(negedge clock);
        cube_in = start_cube;
        moves_in = prog;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        cycles = 0;
        while (!done && cycles < done_timeout) begin
            @(negedge clock);
            cycles++;
            start = row.poke_start && (cycles == 10);
        end
        start = 1'b0;
        if (!done) begin
            $display("timeout: done did not rise within %0d cycles in %s", done_timeout, tag);
            timeouts++;
            return;
        end
        check_count(cycles, expected_latency, {tag, " start to done cycles"});
        result = cube_out;
        if (row.rule == expect_same) begin
            check_cube(result, start_cube, {tag, " result"});
        end else begin
            check_turn_result(result, tag);
        end
        @(negedge clock);
        check_done(done, 1'b0, {tag, " done width"});
        check_cube(cube_out, result, {tag, " held result"});
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        lcg_state = 32'h821b09e8;
        rst = 1'b1;
        start = 1'b0;
        cube_in = '0;
        for (int i = 0; i < max_moves; i++) begin
            moves_in[i] = move_nop0;
        end
        repeat (3) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        check_done(done, 1'b0, "done after reset");
        check_cube(cube_out, '0, "cube_out after reset");
        build_table();
        foreach (stim_table[i]) begin
            if (timeouts == 0) begin
                run_case(i, stim_table[i]);
            end
        end
        $display("cases: %0d, errors: %0d, timeouts: %0d", stim_table.size(), errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/cube_engine.sv
`timescale 1ns/1ns
`default_nettype none

module cube_engine
    import cube_pkg::*;
#(
    parameter int max_moves = 50
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  start,
    input  cube_t                 cube_in,
    input  move_e [max_moves-1:0] moves_in,
    output cube_t                 cube_out,
    output logic                  done
);

    logic  load;
    logic  shift;
    move_e current_move;
    cube_t work_cube;
    cube_t turned_cube;

    move_program #(
        .max_moves(max_moves)
    ) move_program_i (
        .clock(clock),
        .rst(rst),
        .load(load),
        .shift(shift),
        .moves_in(moves_in),
        .current_move(current_move)
    );

    move_sequencer #(
        .max_moves(max_moves)
    ) move_sequencer_i (
        .clock(clock),
        .rst(rst),
        .start(start),
        .cube_in(cube_in),
        .turned_cube(turned_cube),
        .work_cube(work_cube),
        .load(load),
        .shift(shift),
        .cube_out(cube_out),
        .done(done)
    );

    move_permute move_permute_i (
        .move(current_move),
        .cube(work_cube),
        .turned(turned_cube)
    );

endmodule

`default_nettype wire

//--- src/move_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module move_sequencer
    import cube_pkg::*;
#(
    parameter int max_moves = 50
) (
    input  logic  clock,
    input  logic  rst,
    input  logic  start,
    input  cube_t cube_in,
    input  cube_t turned_cube,
    output cube_t work_cube,
    output logic  load,
    output logic  shift,
    output cube_t cube_out,
    output logic  done
);

    localparam int count_width = $clog2(max_moves + 1);

    typedef enum logic [1:0] {
        seq_idle,
        seq_moving,
        seq_done
    } seq_state_e;

    seq_state_e             state;
    logic [count_width-1:0] count;
    logic                   last_move;

    assign load = (state == seq_idle) && start;
    assign shift = (state == seq_moving);
    assign last_move = (count == count_width'(max_moves - 1));

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= seq_idle;
            count <= '0;
            done <= 1'b0;
            cube_out <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                seq_idle: begin
                    count <= '0;
                    if (start) begin
                        state <= seq_moving;
                    end
                end
                seq_moving: begin
                    count <= count + 1'b1;
                    if (last_move) begin
                        state <= seq_done;
                    end
                end
                seq_done: begin
                    cube_out <= work_cube;
                    done <= 1'b1;
                    state <= seq_idle;
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // the working cube takes one turn per moving cycle
    always_ff @(posedge clock) begin
        if (load) begin
            work_cube <= cube_in;
        end else if (shift) begin
            work_cube <= turned_cube;
        end
    end

    done_single_cycle: assert property (
        @(posedge clock) disable iff (rst) done |=> !done
    );

    count_in_range: assert property (
        @(posedge clock) disable iff (rst) (state == seq_moving) |-> (count < max_moves)
    );

endmodule

`default_nettype wire

//--- src/move_program.sv
`timescale 1ns/1ns
`default_nettype none

module move_program
    import cube_pkg::*;
#(
    parameter int max_moves = 50
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  shift,
    input  move_e [max_moves-1:0] moves_in,
    output move_e                 current_move
);

    move_e [max_moves-1:0] program_q;

    // first move sits in the top slot
    assign current_move = program_q[max_moves-1];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < max_moves; i++) begin
                program_q[i] <= move_nop0;
            end
        end else if (load) begin
            program_q <= moves_in;
        end else if (shift) begin
            for (int i = max_moves - 1; i > 0; i--) begin
                program_q[i] <= program_q[i-1];
            end
            program_q[0] <= move_nop0;
        end
    end

    // the sequencer never loads a program while stepping through one
    load_shift_exclusive: assert property (
        @(posedge clock) disable iff (rst) !(load && shift)
    );

endmodule

`default_nettype wire

//--- src/move_permute.sv
`timescale 1ns/1ns
`default_nettype none

module move_permute
    import cube_pkg::*;
(
    input  move_e move,
    input  cube_t cube,
    output cube_t turned
);

    logic [2:0] face;
    logic       turn_en;
    logic       inverse;

    // odd codes are the inverse of the code below them
    assign inverse = move[0];

    always_comb begin
        face = 3'd0;
        turn_en = 1'b1;
        case (move)
            move_u, move_ui: face = 3'd0;
            move_l, move_li: face = 3'd1;
            move_f, move_fi: face = 3'd2;
            move_r, move_ri: face = 3'd3;
            move_b, move_bi: face = 3'd4;
            move_d, move_di: face = 3'd5;
            default: begin
                // no-op codes
                turn_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        turned = cube;
        if (turn_en) begin
            for (int c = 0; c < 5; c++) begin
                for (int k = 0; k < 4; k++) begin
                    if (inverse) begin
                        turned[face_cycles[face][c][k]] =
                            cube[face_cycles[face][c][(k + 1) % 4]];
                    end else begin
                        turned[face_cycles[face][c][(k + 1) % 4]] =
                            cube[face_cycles[face][c][k]];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/cube_pkg.sv
`default_nettype none

package cube_pkg;

    localparam int num_stickers = 54;
    localparam int move_width = 4;

    // face colors in order U, L, F, R, B, D
    typedef logic [2:0] sticker_t;

    // corners 0..23, edges 24..47, centers 48..53
    typedef sticker_t [num_stickers-1:0] cube_t;

    typedef logic [5:0] sticker_idx_t;

    typedef enum logic [move_width-1:0] {
        move_nop0 = 4'd0,
        move_nop1 = 4'd1,
        move_r    = 4'd2,
        move_ri   = 4'd3,
        move_u    = 4'd4,
        move_ui   = 4'd5,
        move_f    = 4'd6,
        move_fi   = 4'd7,
        move_l    = 4'd8,
        move_li   = 4'd9,
        move_b    = 4'd10,
        move_bi   = 4'd11,
        move_d    = 4'd12,
        move_di   = 4'd13,
        move_nop2 = 4'd14,
        move_nop3 = 4'd15
    } move_e;

    // each face lists two side corner cycles, the side edge cycle, its own corners and edges
    // a clockwise turn sends each position to the next one in its cycle
    localparam sticker_idx_t face_cycles [6][5][4] = '{
        // U
        '{'{ 8,  7, 18, 13}, '{11,  6, 17, 12}, '{35, 30, 43, 36},
          '{ 0,  3,  2,  1}, '{24, 27, 26, 25}},
        // L
        '{'{ 0,  8, 20, 16}, '{ 1,  9, 21, 17}, '{25, 34, 45, 40},
          '{ 4,  7,  6,  5}, '{28, 31, 30, 29}},
        // F
        '{'{ 1, 13, 23,  5}, '{ 2, 14, 20,  6}, '{29, 26, 37, 46},
          '{ 8, 11, 10,  9}, '{34, 35, 32, 33}},
        // R
        '{'{10,  2, 18, 22}, '{11,  3, 19, 23}, '{32, 27, 42, 47},
          '{13, 12, 15, 14}, '{37, 36, 39, 38}},
        // B
        '{'{ 0,  4, 22, 12}, '{ 3,  7, 21, 15}, '{24, 31, 44, 39},
          '{16, 19, 18, 17}, '{43, 40, 41, 42}},
        // D
        '{'{ 9, 14, 19,  4}, '{10, 15, 16,  5}, '{33, 38, 41, 28},
          '{20, 23, 22, 21}, '{45, 46, 47, 44}}
    };

    // home face of every sticker as it sits on the solved cube
    localparam sticker_t sticker_face [num_stickers] = '{
        // corners
        3'd0, 3'd0, 3'd0, 3'd0,
        3'd1, 3'd1, 3'd1, 3'd1,
        3'd2, 3'd2, 3'd2, 3'd2,
        3'd3, 3'd3, 3'd3, 3'd3,
        3'd4, 3'd4, 3'd4, 3'd4,
        3'd5, 3'd5, 3'd5, 3'd5,
        // edges
        3'd0, 3'd0, 3'd0, 3'd0,
        3'd1, 3'd1, 3'd1, 3'd1,
        3'd2, 3'd2, 3'd2, 3'd2,
        3'd3, 3'd3, 3'd3, 3'd3,
        3'd4, 3'd4, 3'd4, 3'd4,
        3'd5, 3'd5, 3'd5, 3'd5,
        // centers
        3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5
    };

endpackage

`default_nettype wire
